// ==== design/dacChannel.sv ====
`include "demod_settings.svh"

module dacChannel (
    input  logic                                  clk,
    input  logic                                  rstN,
    input  demodSignalPkg::dacSource_t            select,
    input  logic [`SAMPLE_WIDTH-1:0]              iIn,
    input  logic [`SAMPLE_WIDTH-1:0]              qIn,
    input  logic                                  syncIn,
    input  logic [`SAMPLE_WIDTH-1:0]              iSym,
    input  logic [`SAMPLE_WIDTH-1:0]              qSym,
    input  logic                                  symSync,
    input  logic [demodSignalPkg::FREQ_WIDTH-1:0] freq,
    input  logic [demodSignalPkg::MAG_WIDTH-1:0]  mag,
    input  logic                                  detSync,
    output logic [`SAMPLE_WIDTH-1:0]              dacData,
    output logic                                  dacSync
);

    import demodSignalPkg::*;

    logic [`SAMPLE_WIDTH-1:0] srcData;
    logic                     srcSync;

    // Each source travels with its own strobe.
    always_comb begin
        case (select)
            dacQ: begin
                srcData = qIn;
                srcSync = syncIn;
            end
            dacISym: begin
                srcData = iSym;
                srcSync = symSync;
            end
            dacQSym: begin
                srcData = qSym;
                srcSync = symSync;
            end
            dacFreq: begin
                srcData = {freq, {(`SAMPLE_WIDTH-FREQ_WIDTH){1'b0}}};   // Left justified.
                srcSync = detSync;
            end
            dacMag: begin
                // Offset binary, so zero magnitude sits at negative full scale.
                srcData = {~mag[MAG_WIDTH-1], mag[MAG_WIDTH-2:0],
                           {(`SAMPLE_WIDTH-MAG_WIDTH){1'b0}}};
                srcSync = detSync;
            end
            default: begin
                srcData = iIn;              // dacI and every unused code.
                srcSync = syncIn;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dacData <= '0;
            dacSync <= 1'b0;
        end else begin
            dacSync <= srcSync;
            if (srcSync) begin
                dacData <= srcData;
            end
        end
    end

    dacSyncSingle: assert property (@(posedge clk) disable iff (!rstN) dacSync |=> !dacSync);

endmodule

// ==== design/demod.sv ====
`include "demod_settings.svh"

module demod (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     syncIn,
    input  logic                     rd,
    input  logic                     wr0,
    input  logic                     wr1,
    input  logic                     wr2,
    input  logic                     wr3,
    input  logic [`ADDR_WIDTH-1:0]   addr,
    input  logic [`DATA_WIDTH-1:0]   din,
    input  logic [`SAMPLE_WIDTH-1:0] iRx,
    input  logic [`SAMPLE_WIDTH-1:0] qRx,
    output logic [`DATA_WIDTH-1:0]   dout,
    output logic                     iDataClk,
    output logic                     iBit,
    output logic                     qDataClk,
    output logic                     qBit,
    output logic                     symTimes2Sync,
    output logic                     symSync,
    output logic                     dac0Sync,
    output logic [`SAMPLE_WIDTH-1:0] dac0Data,
    output logic                     dac1Sync,
    output logic [`SAMPLE_WIDTH-1:0] dac1Data,
    output logic                     dac2Sync,
    output logic [`SAMPLE_WIDTH-1:0] dac2Data
);

    import demodRegPkg::*;
    import demodSignalPkg::*;

    controlWord_u             control;      // Decoded here as fields.
    logic [`DATA_WIDTH-1:0]   regsDout;
    logic [FREQ_WIDTH-1:0]    freq;
    logic [MAG_WIDTH-1:0]     mag;
    logic                     detSync;
    logic [`SAMPLE_WIDTH-1:0] iSym;
    logic [`SAMPLE_WIDTH-1:0] qSym;

    assign dout = rd ? regsDout : '0;       // Bus is driven only during a read.

    demodRegs regs_inst (
        .clk(clk), .rstN(rstN), .addr(addr), .din(din),
        .wr0(wr0), .wr1(wr1), .wr2(wr2), .wr3(wr3),
        .symSync(symSync), .dout(regsDout), .control(control)
    );

    fmDetector detector_inst (
        .clk(clk), .rstN(rstN), .syncIn(syncIn), .iIn(iRx), .qIn(qRx),
        .freq(freq), .mag(mag), .detSync(detSync)
    );

    symbolDeskew deskew_inst (
        .clk(clk), .rstN(rstN), .mode(control.fields.mode),
        .syncIn(syncIn), .iIn(iRx), .qIn(qRx), .iSym(iSym), .qSym(qSym),
        .symSync(symSync), .symTimes2Sync(symTimes2Sync),
        .iDataClk(iDataClk), .iBit(iBit), .qDataClk(qDataClk), .qBit(qBit)
    );

    dacChannel dac0_inst (
        .clk(clk), .rstN(rstN), .select(dacSource_t'(control.fields.dac0Select)),
        .iIn(iRx), .qIn(qRx), .syncIn(syncIn), .iSym(iSym), .qSym(qSym), .symSync(symSync),
        .freq(freq), .mag(mag), .detSync(detSync), .dacData(dac0Data), .dacSync(dac0Sync)
    );

    dacChannel dac1_inst (
        .clk(clk), .rstN(rstN), .select(dacSource_t'(control.fields.dac1Select)),
        .iIn(iRx), .qIn(qRx), .syncIn(syncIn), .iSym(iSym), .qSym(qSym), .symSync(symSync),
        .freq(freq), .mag(mag), .detSync(detSync), .dacData(dac1Data), .dacSync(dac1Sync)
    );

    dacChannel dac2_inst (
        .clk(clk), .rstN(rstN), .select(dacSource_t'(control.fields.dac2Select)),
        .iIn(iRx), .qIn(qRx), .syncIn(syncIn), .iSym(iSym), .qSym(qSym), .symSync(symSync),
        .freq(freq), .mag(mag), .detSync(detSync), .dacData(dac2Data), .dacSync(dac2Sync)
    );

endmodule

// ==== design/demodRegPkg.sv ====
package demodRegPkg;

    `include "demod_settings.svh"

    // Demodulation mode, held in byte 0 of the control word.
    typedef enum logic [2:0] {
        modeBpsk  = 3'd0,               // One bit per symbol on I.
        modeQpsk  = 3'd1,               // I and Q sampled together.
        modeOqpsk = 3'd2,               // Q offset by half a symbol.
        mode2Fsk  = 3'd3                // Single data stream, Q mirrors I.
    } demodMode_t;

    // Field view of the control word, one field per byte lane.
    typedef struct packed {
        logic [3:0] reserved3;          // Byte 3 upper nibble, reads zero.
        logic [3:0] dac2Select;         // Byte 3.
        logic [3:0] reserved2;          // Byte 2 upper nibble, reads zero.
        logic [3:0] dac1Select;         // Byte 2.
        logic [3:0] reserved1;          // Byte 1 upper nibble, reads zero.
        logic [3:0] dac0Select;         // Byte 1.
        logic [4:0] reserved0;          // Byte 0 upper bits, read zero.
        demodMode_t mode;               // Byte 0.
    } controlFields_t;

    // The register block sees a raw word and the top level sees fields.
    typedef union packed {
        logic [`DATA_WIDTH-1:0] raw;    // Byte-lane writes and readback.
        controlFields_t fields;         // Select and mode wiring.
    } controlWord_u;

endpackage

// ==== design/demodRegs.sv ====
`include "demod_settings.svh"

module demodRegs (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic [`ADDR_WIDTH-1:0]    addr,
    input  logic [`DATA_WIDTH-1:0]    din,
    input  logic                      wr0,
    input  logic                      wr1,
    input  logic                      wr2,
    input  logic                      wr3,
    input  logic                      symSync,
    output logic [`DATA_WIDTH-1:0]    dout,
    output demodRegPkg::controlWord_u control
);

    // Only mode and the four select bits of each DAC byte are stored.
    localparam logic [`DATA_WIDTH-1:0] CONTROL_MASK = 32'h0F0F_0F07;

    logic                   inSpace;        // Address falls in this block's space.
    logic [7:0]             offset;         // Register offset within the space.
    logic [`DATA_WIDTH-1:0] laneMask;       // One byte of ones per active strobe.
    logic [`DATA_WIDTH-1:0] symbolCount;    // Status word.

    assign inSpace = (addr[`ADDR_WIDTH-1 -: 4] == `DEMOD_SPACE_BASE);
    assign offset = addr[7:0];
    assign laneMask = {{8{wr3}}, {8{wr2}}, {8{wr1}}, {8{wr0}}};

    // Merge the strobed lanes into the stored word, reserved bits forced low.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            control.raw <= '0;
        end else if (inSpace && (offset == `REG_CONTROL)) begin
            control.raw <= ((control.raw & ~laneMask) | (din & laneMask)) & CONTROL_MASK;
        end
    end

    // Symbol counter wraps at 2^32.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            symbolCount <= '0;
        end else if (symSync) begin
            symbolCount <= symbolCount + 1'b1;
        end
    end

    // Readback follows the address in the same cycle.
    always_comb begin
        dout = '0;                          // Outside the space or unmapped.
        if (inSpace) begin
            case (offset)
                `REG_CONTROL: dout = control.raw;
                `REG_STATUS:  dout = symbolCount;
                default:      dout = '0;
            endcase
        end
    end

endmodule

// ==== design/demodSignalPkg.sv ====
package demodSignalPkg;

    // Monitor source for a DAC channel. Codes above dacMag act like dacI.
    typedef enum logic [3:0] {
        dacI    = 4'd0,                 // Raw I sample, paced by syncIn.
        dacQ    = 4'd1,                 // Raw Q sample, paced by syncIn.
        dacISym = 4'd2,                 // I symbol, paced by symSync.
        dacQSym = 4'd3,                 // Q symbol, paced by symSync.
        dacFreq = 4'd4,                 // Discriminator, paced by detSync.
        dacMag  = 4'd5                  // Magnitude, paced by detSync.
    } dacSource_t;

    // Detector output widths.
    localparam int FREQ_WIDTH = 8;      // Top byte of the 19-bit cross product.
    localparam int MAG_WIDTH = 9;       // Top 9 bits of the 18-bit magnitude.

endpackage

// ==== design/demod_settings.svh ====
`ifndef DEMOD_SETTINGS_SVH
`define DEMOD_SETTINGS_SVH

// Width of the I and Q sample words and of every DAC word.
`define SAMPLE_WIDTH 18

// Control processor bus.
`define ADDR_WIDTH 12                   // Top nibble picks a 256-byte space.
`define DATA_WIDTH 32                   // Four byte lanes, one write strobe each.

// Upper address nibble of the demodulator's register space.
`define DEMOD_SPACE_BASE 4'h0

// Register offsets inside the 256-byte space.
`define REG_CONTROL 8'h00               // Mode and the three DAC selects.
`define REG_STATUS 8'h04                // Read-only count of received symbols.

`endif

// ==== design/fmDetector.sv ====
`include "demod_settings.svh"

module fmDetector (
    input  logic                                 clk,
    input  logic                                 rstN,
    input  logic                                 syncIn,
    input  logic [`SAMPLE_WIDTH-1:0]             iIn,
    input  logic [`SAMPLE_WIDTH-1:0]             qIn,
    output logic [demodSignalPkg::FREQ_WIDTH-1:0] freq,
    output logic [demodSignalPkg::MAG_WIDTH-1:0]  mag,
    output logic                                 detSync
);

    import demodSignalPkg::*;

    localparam int PROD_BITS = 9;           // Upper bits of each component used in the product.

    logic [`SAMPLE_WIDTH-1:0]      absI;
    logic [`SAMPLE_WIDTH-1:0]      absQ;
    logic [`SAMPLE_WIDTH-1:0]      bigAbs;       // Larger of |I| and |Q|.
    logic [`SAMPLE_WIDTH-1:0]      smallAbs;     // Smaller of |I| and |Q|.
    logic [`SAMPLE_WIDTH-1:0]      magSum;
    logic signed [PROD_BITS-1:0]   curI;
    logic signed [PROD_BITS-1:0]   curQ;
    logic signed [PROD_BITS-1:0]   prevI;        // Previous sample, truncated.
    logic signed [PROD_BITS-1:0]   prevQ;
    logic signed [2*PROD_BITS-1:0] crossIq;      // prevI * curQ.
    logic signed [2*PROD_BITS-1:0] crossQi;      // prevQ * curI.
    logic signed [2*PROD_BITS:0]   crossDiff;
    logic                          stage1Sync;

    // Unsigned magnitudes, so full-scale negative still fits in 18 bits.
    assign absI = iIn[`SAMPLE_WIDTH-1] ? -iIn : iIn;
    assign absQ = qIn[`SAMPLE_WIDTH-1] ? -qIn : qIn;
    assign curI = $signed(iIn[`SAMPLE_WIDTH-1 -: PROD_BITS]);
    assign curQ = $signed(qIn[`SAMPLE_WIDTH-1 -: PROD_BITS]);

    // First stage sorts the magnitudes and forms both cross products.
    always_ff @(posedge clk) begin
        if (syncIn) begin
            bigAbs <= (absI > absQ) ? absI : absQ;
            smallAbs <= (absI > absQ) ? absQ : absI;
            crossIq <= prevI * curQ;
            crossQi <= prevQ * curI;
            prevI <= curI;                   // Held for the next sample.
            prevQ <= curQ;
        end
    end

    assign magSum = bigAbs + (smallAbs >> 1);    // Alpha max plus beta min.
    assign crossDiff = crossIq - crossQi;        // Sine of the phase step.

    // Second stage keeps the top bits of each result.
    always_ff @(posedge clk) begin
        if (stage1Sync) begin
            mag <= magSum[`SAMPLE_WIDTH-1 -: MAG_WIDTH];
            freq <= crossDiff[2*PROD_BITS -: FREQ_WIDTH];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            stage1Sync <= 1'b0;
            detSync <= 1'b0;
        end else begin
            stage1Sync <= syncIn;
            detSync <= stage1Sync;           // Two cycles after syncIn.
        end
    end

    // The two-stage pipeline only holds if samples are never back to back.
    syncSpacing: assert property (@(posedge clk) disable iff (!rstN) syncIn |=> !syncIn);

endmodule

// ==== design/symbolDeskew.sv ====
`include "demod_settings.svh"

module symbolDeskew (
    input  logic                     clk,
    input  logic                     rstN,
    input  demodRegPkg::demodMode_t  mode,
    input  logic                     syncIn,
    input  logic [`SAMPLE_WIDTH-1:0] iIn,
    input  logic [`SAMPLE_WIDTH-1:0] qIn,
    output logic [`SAMPLE_WIDTH-1:0] iSym,
    output logic [`SAMPLE_WIDTH-1:0] qSym,
    output logic                     symSync,
    output logic                     symTimes2Sync,
    output logic                     iDataClk,
    output logic                     iBit,
    output logic                     qDataClk,
    output logic                     qBit
);

    import demodRegPkg::*;

    logic                     symPhase;     // High when the next sample is a symbol.
    logic [`SAMPLE_WIDTH-1:0] qDelay;       // Q of the previous 2x sample.

    // Strobes and the symbol phase.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            symPhase <= 1'b0;
            symTimes2Sync <= 1'b0;
            symSync <= 1'b0;
        end else begin
            symTimes2Sync <= syncIn;
            symSync <= syncIn & symPhase;   // Second, fourth, ... sample after reset.
            if (syncIn) begin
                symPhase <= ~symPhase;
            end
        end
    end

    // Symbol registers, Q taken half a symbol late in offset QPSK.
    always_ff @(posedge clk) begin
        if (syncIn) begin
            qDelay <= qIn;
            if (symPhase) begin
                iSym <= iIn;
                qSym <= (mode == modeOqpsk) ? qDelay : qIn;
            end
        end
    end

    // Hard decisions one cycle after each symbol.
    always_ff @(posedge clk) begin
        if (!rstN) begin
            iDataClk <= 1'b0;
            qDataClk <= 1'b0;
            iBit <= 1'b0;
            qBit <= 1'b0;
        end else begin
            iDataClk <= symSync;
            qDataClk <= symSync;
            if (symSync) begin
                iBit <= ~iSym[`SAMPLE_WIDTH-1];
                qBit <= (mode == mode2Fsk) ? ~iSym[`SAMPLE_WIDTH-1] : ~qSym[`SAMPLE_WIDTH-1];
            end
        end
    end

    // Symbols are every second sample and samples sit at least two cycles apart.
    dataClkSpacing: assert property (@(posedge clk) disable iff (!rstN)
        (iDataClk || qDataClk) |-> !$past(iDataClk || qDataClk)
            && !$past(iDataClk || qDataClk, 2) && !$past(iDataClk || qDataClk, 3));

endmodule

// ==== run.sh ====
#!/bin/sh
# Builds the demodulator testbench with Verilator and runs it into sim.log.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module demodTb -f verilog.f -o demodSim \
    > build.log 2>&1 \
    && ./obj_dir/demodSim > sim.log 2>&1 \
    && cat sim.log \
    || { echo "Build or simulation error, see build.log and sim.log."; exit 1; }
grep -q "Result: FAILED" sim.log && { echo "Simulation failed."; exit 1; } || echo "Simulation passed."

// ==== test/demodChecker.sv ====
`include "demod_settings.svh"

module demodChecker (
    input  logic                     clk,
    input  logic                     rstN,
    input  logic                     syncIn,
    input  logic [`SAMPLE_WIDTH-1:0] iRx,
    input  logic [`SAMPLE_WIDTH-1:0] qRx,
    input  logic                     symSync,
    input  logic                     symTimes2Sync,
    input  logic                     iDataClk,
    input  logic                     iBit,
    input  logic                     qDataClk,
    input  logic                     qBit,
    input  logic                     dac0Sync,
    input  logic [`SAMPLE_WIDTH-1:0] dac0Data,
    input  logic                     dac1Sync,
    input  logic [`SAMPLE_WIDTH-1:0] dac1Data,
    input  logic                     dac2Sync,
    input  logic [`SAMPLE_WIDTH-1:0] dac2Data,
    input  demodRegPkg::demodMode_t  mode,
    input  logic [3:0]               sel0,
    input  logic [3:0]               sel1,
    input  logic [3:0]               sel2,
    input  logic                     testEnd,
    input  int                       testId,
    input  int                       tbErrors,
    input  logic                     finalReport,
    output int                       failedTests,
    output int                       symCount,
    output logic                     busy
);

    import demodRegPkg::*;
    import demodSignalPkg::*;

    logic [18:0] expQ0[$];                      // Bit 18 marks a value that is compared.
    logic [18:0] expQ1[$];
    logic [18:0] expQ2[$];
    logic [1:0]  bitQ[$];                       // Expected {iBit, qBit} per symbol.
    logic [2:0]  dacDue [3];                    // Expected DAC strobes, bit 0 due now.
    logic        dacSyncs [3];
    logic [17:0] dacDatas [3];
    logic [3:0]  sels [3];
    logic        phase, symSyncDue, clkDue, lastSync, havePrev;
    logic [17:0] prevI, prevQ;                  // Previous 2x sample.
    int          testFailures, testsRun;

    assign dacSyncs[0] = dac0Sync;
    assign dacSyncs[1] = dac1Sync;
    assign dacSyncs[2] = dac2Sync;
    assign dacDatas[0] = dac0Data;
    assign dacDatas[1] = dac1Data;
    assign dacDatas[2] = dac2Data;
    assign sels[0] = sel0;
    assign sels[1] = sel1;
    assign sels[2] = sel2;

    function automatic logic [17:0] absValue(input logic [17:0] x);
        return x[17] ? 18'(-x) : x;             // Full-scale negative still fits unsigned.
    endfunction

    // Larger magnitude plus half the smaller, top nine bits kept.
    function automatic logic [8:0] refMag(input logic [17:0] i, input logic [17:0] q);
        logic [17:0] a;
        logic [17:0] b;
        logic [17:0] sum;
        a = absValue(i);
        b = absValue(q);
        sum = (a > b) ? a + (b >> 1) : b + (a >> 1);
        return sum[17:9];
    endfunction

    // Cross product of the upper nine bits, bits 18 to 11 of the difference.
    function automatic logic [7:0] refFreq(input logic [17:0] pi, input logic [17:0] pq,
                                           input logic [17:0] ci, input logic [17:0] cq);
        int a;
        int b;
        int c;
        int d;
        int diff;
        a = $signed(pi[17:9]);
        b = $signed(pq[17:9]);
        c = $signed(ci[17:9]);
        d = $signed(cq[17:9]);
        diff = a * d - b * c;
        return diff[18:11];
    endfunction

    function automatic logic [17:0] dacReference(input logic [3:0] sel, input logic [17:0] i,
                                                 input logic [17:0] q, input logic [17:0] si,
                                                 input logic [17:0] sq, input logic [7:0] f,
                                                 input logic [8:0] m);
        case (sel)
            dacQ:    return q;
            dacISym: return si;
            dacQSym: return sq;
            dacFreq: return {f, 10'd0};
            dacMag:  return {~m[8], m[7:0], 9'd0};  // Offset binary magnitude.
            default: return i;
        endcase
    endfunction

    function automatic int strobeDelay(input logic [3:0] sel);
        case (sel)
            dacISym, dacQSym: return 2;         // Through the symbol register.
            dacFreq, dacMag:  return 3;         // Through the detector pipeline.
            default:          return 1;
        endcase
    endfunction

    function automatic string testName(input int id);
        case (id)
            1: return "reset state";
            2: return "register access";
            3: return "raw and magnitude outputs";
            4: return "frequency discriminator";
            5: return "QPSK symbols";
            6: return "OQPSK symbols";
            7: return "2FSK bits";
            default: return "symbol count";
        endcase
    endfunction

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("[FAIL] %s expected 0x%h actual 0x%h at %0t", name, expected, actual, $time);
        testFailures++;
    endtask

    task automatic pushExpected(input int ch, input logic [18:0] value);
        case (ch)
            0: expQ0.push_back(value);
            1: expQ1.push_back(value);
            default: expQ2.push_back(value);
        endcase
    endtask

    task automatic popExpected(input int ch, output logic [18:0] value);
        case (ch)
            0: value = expQ0.pop_front();
            1: value = expQ1.pop_front();
            default: value = expQ2.pop_front();
        endcase
    endtask

    // Inputs and outputs are both settled at the falling edge.
    always @(negedge clk) begin
        logic [18:0] expected;
        logic [17:0] symI;
        logic [17:0] symQ;
        logic [17:0] refData;
        logic [1:0]  bits;
        int          lat;
        if (!rstN) begin
            expQ0.delete();
            expQ1.delete();
            expQ2.delete();
            bitQ.delete();
            dacDue = '{3'b000, 3'b000, 3'b000};
            {phase, symSyncDue, clkDue, lastSync, havePrev} = '0;
            symCount = 0;
            testFailures = 0;
            testsRun = 0;
            failedTests = 0;
        end else begin
            if (symTimes2Sync !== lastSync) reportMismatch("symTimes2Sync", lastSync, symTimes2Sync);
            if (symSync !== symSyncDue) reportMismatch("symSync", symSyncDue, symSync);
            if (iDataClk !== clkDue) reportMismatch("iDataClk", clkDue, iDataClk);
            if (qDataClk !== clkDue) reportMismatch("qDataClk", clkDue, qDataClk);
            if (clkDue) begin
                bits = bitQ.pop_front();
                if (iBit !== bits[1]) reportMismatch("iBit", bits[1], iBit);
                if (qBit !== bits[0]) reportMismatch("qBit", bits[0], qBit);
            end
            for (int ch = 0; ch < 3; ch++) begin
                if (dacSyncs[ch] !== dacDue[ch][0]) begin
                    reportMismatch($sformatf("dac%0dSync", ch), dacDue[ch][0], dacSyncs[ch]);
                end
                if (dacDue[ch][0]) begin
                    popExpected(ch, expected);
                    if (expected[18] && dacDatas[ch] !== expected[17:0]) begin
                        reportMismatch($sformatf("dac%0dData", ch), expected[17:0], dacDatas[ch]);
                    end
                end
                dacDue[ch] = dacDue[ch] >> 1;
            end
            clkDue = symSyncDue;                // Data clocks trail symSync by a cycle.
            symSyncDue = 1'b0;
            lastSync = syncIn;
            if (syncIn) begin
                symI = iRx;
                symQ = (mode == modeOqpsk) ? prevQ : qRx;   // Q half a symbol late.
                if (phase) begin
                    symSyncDue = 1'b1;
                    symCount++;                 // The status word counts these symbols.
                    bitQ.push_back({~symI[17], (mode == mode2Fsk) ? ~symI[17] : ~symQ[17]});
                end
                for (int ch = 0; ch < 3; ch++) begin
                    lat = strobeDelay(sels[ch]);
                    if (lat != 2 || phase) begin
                        refData = dacReference(sels[ch], iRx, qRx, symI, symQ,
                                               refFreq(prevI, prevQ, iRx, qRx), refMag(iRx, qRx));
                        pushExpected(ch, {(sels[ch] != dacFreq) || havePrev, refData});
                        dacDue[ch][lat-1] = 1'b1;
                    end
                end
                prevI = iRx;
                prevQ = qRx;
                havePrev = 1'b1;
                phase = ~phase;                 // Every second sample is a symbol.
            end
            if (testEnd) begin
                testFailures += tbErrors;
                testsRun++;
                if (testFailures == 0) begin
                    $display("Test %0d, %s: passed", testId, testName(testId));
                end else begin
                    $display("Test %0d, %s: %0d errors", testId, testName(testId), testFailures);
                    failedTests++;
                end
                testFailures = 0;
            end
            if (finalReport) begin
                $display("Tests run: %0d, passed: %0d, failed: %0d", testsRun,
                         testsRun - failedTests, failedTests);
            end
        end
        busy = (expQ0.size() + expQ1.size() + expQ2.size() + bitQ.size()) != 0
            || (dacDue[0] | dacDue[1] | dacDue[2]) != 3'b000 || symSyncDue || clkDue;
    end

endmodule

// ==== test/demodTb.sv ====
`include "demod_settings.svh"

module demodTb;

    import demodRegPkg::*;
    import demodSignalPkg::*;

    localparam int SAMPLES_PER_TEST = 40;
    localparam int DRAIN_LIMIT = 60;                        // Cycles allowed for outputs to settle.
    localparam logic [31:0] CONTROL_MASK = 32'h0F0F_0F07;   // Mode and the three select nibbles.

    logic clk = 1'b0;
    logic rstN, syncIn, rd, wr0, wr1, wr2, wr3;
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`DATA_WIDTH-1:0] din, dout;
    logic [`SAMPLE_WIDTH-1:0] iRx, qRx, dac0Data, dac1Data, dac2Data;
    logic iDataClk, iBit, qDataClk, qBit, symTimes2Sync, symSync, dac0Sync, dac1Sync, dac2Sync;
    demodMode_t expMode;                                    // Mode the checker models.
    logic [3:0] expSel0, expSel1, expSel2;
    logic testEnd, finalReport, busy;
    int testId, tbErrors, failedTests, symCount;
    logic [31:0] shadow;                                    // Expected control word.

    always #5 clk = ~clk;

    demod demod_inst (
        .clk(clk), .rstN(rstN), .syncIn(syncIn), .rd(rd), .wr0(wr0), .wr1(wr1), .wr2(wr2),
        .wr3(wr3), .addr(addr), .din(din), .iRx(iRx), .qRx(qRx), .dout(dout),
        .iDataClk(iDataClk), .iBit(iBit), .qDataClk(qDataClk), .qBit(qBit),
        .symTimes2Sync(symTimes2Sync), .symSync(symSync), .dac0Sync(dac0Sync),
        .dac0Data(dac0Data), .dac1Sync(dac1Sync), .dac1Data(dac1Data), .dac2Sync(dac2Sync),
        .dac2Data(dac2Data)
    );

    demodChecker checker_inst (
        .clk(clk), .rstN(rstN), .syncIn(syncIn), .iRx(iRx), .qRx(qRx), .symSync(symSync),
        .symTimes2Sync(symTimes2Sync), .iDataClk(iDataClk), .iBit(iBit), .qDataClk(qDataClk),
        .qBit(qBit), .dac0Sync(dac0Sync), .dac0Data(dac0Data), .dac1Sync(dac1Sync),
        .dac1Data(dac1Data), .dac2Sync(dac2Sync), .dac2Data(dac2Data), .mode(expMode),
        .sel0(expSel0), .sel1(expSel1), .sel2(expSel2), .testEnd(testEnd), .testId(testId),
        .tbErrors(tbErrors), .finalReport(finalReport), .failedTests(failedTests),
        .symCount(symCount), .busy(busy)
    );

    task automatic stepCycle();
        @(posedge clk);
        #1;                                                 // Inputs change just after the edge.
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[FAIL] %s expected 0x%h actual 0x%h", name, expected, actual);
            tbErrors++;
        end
    endtask

    task automatic writeControl(input logic [31:0] data, input logic [3:0] lanes);
        addr = {`DEMOD_SPACE_BASE, `REG_CONTROL};
        din = data;
        {wr3, wr2, wr1, wr0} = lanes;
        stepCycle();
        {wr3, wr2, wr1, wr0} = 4'b0000;
        for (int n = 0; n < 4; n++) begin
            if (lanes[n]) begin
                shadow[8*n +: 8] = data[8*n +: 8];          // Each strobed lane takes its byte.
            end
        end
        shadow = shadow & CONTROL_MASK;                     // Reserved bits read 0.
    endtask

    task automatic readReg(input logic [`ADDR_WIDTH-1:0] address, output logic [31:0] data);
        addr = address;
        rd = 1'b1;
        #2;                                                 // Readback is combinational.
        data = dout;
        rd = 1'b0;
        stepCycle();
    endtask

    task automatic finishTest(input int id);
        testId = id;
        testEnd = 1'b1;                                     // Checker prints the test's line.
        stepCycle();
        testEnd = 1'b0;
        tbErrors = 0;
    endtask

    task automatic sendSamples(input int count);
        repeat (count) begin
            iRx = 18'($urandom);
            qRx = 18'($urandom);
            syncIn = 1'b1;
            stepCycle();
            syncIn = 1'b0;
            repeat ($urandom_range(2, 1)) stepCycle();      // Strobes two or three cycles apart.
        end
    endtask

    // Configures mode and selects, streams samples and waits for the checker to drain.
    task automatic runStream(input int id, input demodMode_t m, input logic [3:0] s0,
                             input logic [3:0] s1, input logic [3:0] s2, output bit ok);
        int cycles;
        writeControl({4'h0, s2, 4'h0, s1, 4'h0, s0, 5'h0, m}, 4'hF);
        expMode = m;
        expSel0 = s0;
        expSel1 = s1;
        expSel2 = s2;
        sendSamples(SAMPLES_PER_TEST);
        cycles = 0;
        while (busy && cycles < DRAIN_LIMIT) begin
            stepCycle();
            cycles++;
        end
        ok = !busy;
        if (ok) begin
            finishTest(id);
        end else begin
            $display("Test %0d timed out: the DUT did not deliver every expected strobe.", id);
        end
    endtask

    initial begin
        bit ok;
        logic [31:0] value;
        {rstN, syncIn, rd, wr0, wr1, wr2, wr3, testEnd, finalReport} = '0;
        {addr, din, iRx, qRx} = '0;
        {expSel0, expSel1, expSel2, shadow} = '0;
        expMode = modeBpsk;
        testId = 0;
        tbErrors = 0;
        void'($urandom(32'hd2f5));
        repeat (16) @(posedge clk);
        #1;
        rstN = 1'b1;
        checkValue("dac0Data", 0, dac0Data);                // Everything idles at zero.
        checkValue("dac1Data", 0, dac1Data);
        checkValue("dac2Data", 0, dac2Data);
        checkValue("{dac0Sync,dac1Sync,dac2Sync}", 0, {dac0Sync, dac1Sync, dac2Sync});
        checkValue("{symSync,symTimes2Sync}", 0, {symSync, symTimes2Sync});
        checkValue("{iDataClk,iBit,qDataClk,qBit}", 0, {iDataClk, iBit, qDataClk, qBit});
        readReg({`DEMOD_SPACE_BASE, `REG_CONTROL}, value);
        checkValue("control", 0, value);
        finishTest(1);
        writeControl(32'hFFFF_FFFF, 4'b0001);
        readReg({`DEMOD_SPACE_BASE, `REG_CONTROL}, value);
        checkValue("control", shadow, value);
        writeControl(32'h1234_5678, 4'b0110);
        readReg({`DEMOD_SPACE_BASE, `REG_CONTROL}, value);
        checkValue("control", shadow, value);
        writeControl(32'hA5C3_E1F6, 4'b1000);
        readReg({`DEMOD_SPACE_BASE, `REG_CONTROL}, value);
        checkValue("control", shadow, value);
        readReg({`DEMOD_SPACE_BASE, 8'h08}, value);
        checkValue("dout at unmapped offset", 0, value);
        readReg({4'h7, `REG_STATUS}, value);               // Another block's space.
        checkValue("dout outside the space", 0, value);
        writeControl(32'h0, 4'hF);
        finishTest(2);
        ok = 1'b1;
        runStream(3, modeBpsk, dacI, dacQ, dacMag, ok);
        if (ok) runStream(4, modeBpsk, dacFreq, dacMag, dacFreq, ok);
        if (ok) runStream(5, modeQpsk, dacISym, dacQSym, dacI, ok);
        if (ok) runStream(6, modeOqpsk, dacISym, dacQSym, dacQ, ok);
        if (ok) runStream(7, mode2Fsk, dacISym, dacQSym, 4'd9, ok);  // Unused code acts as dacI.
        if (ok) begin
            readReg({`DEMOD_SPACE_BASE, `REG_STATUS}, value);
            checkValue("status", symCount, value);
            finishTest(8);
        end
        finalReport = 1'b1;
        stepCycle();
        finalReport = 1'b0;
        if (ok && failedTests == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+design
design/demodRegPkg.sv
design/demodSignalPkg.sv
design/demodRegs.sv
design/fmDetector.sv
design/symbolDeskew.sv
design/dacChannel.sv
design/demod.sv
test/demodChecker.sv
test/demodTb.sv
